// ==== src/alu_op_pkg.sv ====
`default_nettype none

package alu_op_pkg;

	typedef enum logic [3:0] {
		ALU_OP_ADD    = 4'd0,
		ALU_OP_SUB    = 4'd1,
		ALU_OP_AND    = 4'd2,
		ALU_OP_OR     = 4'd3,
		ALU_OP_XOR    = 4'd4,
		ALU_OP_SLL    = 4'd5,
		ALU_OP_SRL    = 4'd6,
		ALU_OP_SRA    = 4'd7,
		ALU_OP_EQ     = 4'd8,
		ALU_OP_LT     = 4'd9,
		ALU_OP_LTU    = 4'd10,
		ALU_OP_PLUS_4 = 4'd11
	} cs_alu_op;

	// Carry and left shifts move upward, so these start with the low half
	localparam cs_alu_op first_low_ops [7] = '{
		ALU_OP_ADD, ALU_OP_SUB, ALU_OP_AND, ALU_OP_OR,
		ALU_OP_XOR, ALU_OP_PLUS_4, ALU_OP_SLL
	};

	// Right shifts and compares start with the high half
	localparam cs_alu_op first_high_ops [5] = '{
		ALU_OP_SRL, ALU_OP_SRA, ALU_OP_EQ, ALU_OP_LT, ALU_OP_LTU
	};

	localparam cs_alu_op cmp_ops [3] = '{ALU_OP_EQ, ALU_OP_LT, ALU_OP_LTU};

endpackage

`default_nettype wire

// ==== src/alu_data_pkg.sv ====
`default_nettype none

package alu_data_pkg;

	typedef logic [31:0] word_t;
	typedef logic [15:0] half_t;

	typedef struct packed {
		alu_op_pkg::cs_alu_op op;
		// Turns EQ, LT, LTU into NE, GE, GEU
		logic                 flip;
		word_t                a;
		word_t                b;
	} alu_req_t;

	typedef struct packed {
		alu_op_pkg::cs_alu_op op;
		logic                 first;
		// Half of the result this beat produces
		logic                 is_high;
		logic                 cmp_req;
		logic                 cmp_flip;
		half_t                a;
		half_t                b;
	} slice_beat_t;

	typedef struct packed {
		word_t result;
		logic  cmp;
	} alu_rsp_t;

endpackage

`default_nettype wire

// ==== src/operand_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module operand_sequencer (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      req_valid_i,
	input  alu_data_pkg::alu_req_t    req_i,
	input  logic                      shift_big_i,
	output logic                      beat_valid_o,
	output alu_data_pkg::slice_beat_t beat_o
);
	import alu_op_pkg::*;
	import alu_data_pkg::*;

	typedef enum logic {
		FIRST,
		SECOND
	} seq_state_t;

	seq_state_t state_q;
	logic       busy_q;
	logic       swap_q;
	alu_req_t   req_q;

	logic  accept;
	logic  low_first, high_first, is_cmp, is_shift;
	logic  first_is_high, beat_is_high, data_is_high;
	half_t a_half, b_half;

	// New request only when idle or while the second beat goes out
	assign accept = req_valid_i && (!busy_q || state_q == SECOND);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= FIRST;
			busy_q <= 1'b0;
			swap_q <= 1'b0;
		end else if (busy_q && state_q == FIRST) begin
			state_q <= SECOND;
			swap_q <= shift_big_i;
		end else begin
			state_q <= FIRST;
			busy_q <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= req_i;
		end
	end

	always_comb begin
		low_first = 1'b0;
		high_first = 1'b0;
		is_cmp = 1'b0;
		for (int i = 0; i < $size(first_low_ops); i++) begin
			if (req_q.op == first_low_ops[i]) low_first = 1'b1;
		end
		for (int i = 0; i < $size(first_high_ops); i++) begin
			if (req_q.op == first_high_ops[i]) high_first = 1'b1;
		end
		for (int i = 0; i < $size(cmp_ops); i++) begin
			if (req_q.op == cmp_ops[i]) is_cmp = 1'b1;
		end
	end

	assign is_shift = req_q.op inside {ALU_OP_SLL, ALU_OP_SRL, ALU_OP_SRA};
	// Ops in neither list start low
	assign first_is_high = high_first && !low_first;
	assign beat_is_high = (state_q == FIRST) ? first_is_high : !first_is_high;
	// Shift past 16 feeds the same data half twice
	assign data_is_high = (state_q == SECOND && swap_q) ? first_is_high : beat_is_high;

	assign a_half = data_is_high ? req_q.a[31:16] : req_q.a[15:0];
	// Shift amount lives in b[4:0] for both beats
	assign b_half = (data_is_high && !is_shift) ? req_q.b[31:16] : req_q.b[15:0];

	always_comb begin
		// Idle beat of AND in first cycle leaves slice state alone
		beat_o.op = ALU_OP_AND;
		beat_o.first = 1'b1;
		beat_o.is_high = 1'b0;
		beat_o.cmp_req = 1'b0;
		beat_o.cmp_flip = 1'b0;
		beat_o.a = '0;
		beat_o.b = '0;
		if (busy_q) begin
			beat_o.op = req_q.op;
			beat_o.first = (state_q == FIRST);
			beat_o.is_high = beat_is_high;
			beat_o.cmp_req = is_cmp;
			beat_o.cmp_flip = req_q.flip;
			beat_o.a = a_half;
			beat_o.b = b_half;
		end
	end

	assign beat_valid_o = busy_q;

endmodule

`default_nettype wire

// ==== src/alu_sbm.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_sbm (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 first_cycle,
	input  alu_op_pkg::cs_alu_op op_i,
	input  logic                 cmp_req_i,
	input  logic                 cmp_flip_i,
	input  alu_data_pkg::half_t  a_i,
	input  alu_data_pkg::half_t  b_i,
	output logic                 shift_bigger_then_16_o,
	output alu_data_pkg::half_t  result_o,
	output logic                 cmp_result_o,
	output logic                 cmp_result_valid_o
);
	import alu_op_pkg::*;
	import alu_data_pkg::*;

	half_t       add_a, add_b;
	logic        add_cin;
	logic [16:0] add_out;
	logic        carry_used;

	logic        shift_used;
	logic [3:0]  shamt;
	half_t       shift_in, shift_out, shift_out_rev;
	half_t       a_rev;
	half_t       fill_bits, fill_out, fill_out_rev;
	half_t       fill_options [16];

	logic        halves_differ, sign_diff, half_lt;
	logic        verdict_now, result_now, final_bit, cmp_bit;
	logic        early_verdict, early_result;

	logic        carry_q;
	logic        early_verdict_q;
	logic        early_result_q;
	half_t       saved_q;

	// Carry out of the low half, used by the second beat
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			carry_q <= 1'b0;
		end else if (first_cycle && carry_used) begin
			carry_q <= add_out[16];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			early_verdict_q <= 1'b0;
			early_result_q <= 1'b0;
		end else if (first_cycle) begin
			early_verdict_q <= early_verdict;
			early_result_q <= early_result;
		end else begin
			early_verdict_q <= 1'b0;
		end
	end

	// First-beat shifter input, source of the bits crossing the half boundary
	always_ff @(posedge clk) begin
		if (first_cycle) begin
			saved_q <= shift_in;
		end
	end

	assign add_out = {1'b0, add_a} + {1'b0, add_b} + {16'b0, add_cin};
	assign carry_used = op_i inside {ALU_OP_ADD, ALU_OP_SUB};

	assign shamt = b_i[3:0];
	assign shift_used = op_i inside {ALU_OP_SLL, ALU_OP_SRL, ALU_OP_SRA};
	assign shift_bigger_then_16_o = shift_used && b_i[4];
	assign shift_out = shift_in >> shamt;
	assign a_rev = {<<{a_i}};
	assign shift_out_rev = {<<{shift_out}};
	assign fill_out_rev = {<<{fill_out}};

	// Top shamt bits come from the fill source
	for (genvar i = 0; i < 16; i++) begin : g_fill
		if (i == 0) begin : g_none
			assign fill_options[i] = shift_out;
		end else begin : g_merge
			assign fill_options[i] = {fill_bits[i-1:0], shift_out[15-i:0]};
		end
	end
	assign fill_out = fill_options[shamt];

	assign halves_differ = (a_i != b_i);
	assign sign_diff = a_i[15] ^ b_i[15];
	assign half_lt = (a_i < b_i);

	// Compare verdict comes early from the high halves when they differ
	always_comb begin
		verdict_now = halves_differ;
		result_now = half_lt;
		final_bit = half_lt;
		case (op_i)
			ALU_OP_EQ: begin
				result_now = 1'b0;
				final_bit = !halves_differ;
			end
			ALU_OP_LT: begin
				if (sign_diff) result_now = a_i[15];
			end
			ALU_OP_LTU: begin
				result_now = half_lt;
			end
			default: begin
				verdict_now = 1'b0;
			end
		endcase
		early_verdict = first_cycle && verdict_now;
		early_result = result_now;
		if (first_cycle) begin
			cmp_bit = result_now;
		end else if (early_verdict_q) begin
			cmp_bit = early_result_q;
		end else begin
			cmp_bit = final_bit;
		end
	end

	assign cmp_result_o = cmp_bit ^ cmp_flip_i;
	assign cmp_result_valid_o = cmp_req_i && (early_verdict || !first_cycle);

	always_comb begin
		add_a = a_i;
		add_b = b_i;
		add_cin = 1'b0;
		shift_in = a_i;
		fill_bits = '0;
		result_o = '0;
		case (op_i)
			ALU_OP_ADD: begin
				add_cin = first_cycle ? 1'b0 : carry_q;
				result_o = add_out[15:0];
			end
			ALU_OP_SUB: begin
				add_b = ~b_i;
				add_cin = first_cycle ? 1'b1 : carry_q;
				result_o = add_out[15:0];
			end
			ALU_OP_PLUS_4: begin
				// Works on b and passes the high half with no carry
				add_a = b_i;
				add_b = first_cycle ? 16'd4 : 16'd0;
				result_o = add_out[15:0];
			end
			ALU_OP_AND: result_o = a_i & b_i;
			ALU_OP_OR:  result_o = a_i | b_i;
			ALU_OP_XOR: result_o = a_i ^ b_i;
			ALU_OP_EQ, ALU_OP_LT, ALU_OP_LTU: begin
				result_o = {15'b0, cmp_bit};
			end
			ALU_OP_SRL: begin
				if (first_cycle && shift_bigger_then_16_o) begin
					shift_in = '0;
				end else if (first_cycle) begin
					result_o = shift_out;
				end else begin
					fill_bits = saved_q;
					result_o = fill_out;
				end
			end
			ALU_OP_SRA: begin
				if (first_cycle && shift_bigger_then_16_o) begin
					shift_in = {16{a_i[15]}};
					result_o = {16{a_i[15]}};
				end else begin
					fill_bits = first_cycle ? {16{a_i[15]}} : saved_q;
					result_o = fill_out;
				end
			end
			ALU_OP_SLL: begin
				// Left shift as a right shift on reversed bits
				if (first_cycle && shift_bigger_then_16_o) begin
					shift_in = '0;
				end else if (first_cycle) begin
					shift_in = a_rev;
					result_o = shift_out_rev;
				end else begin
					shift_in = a_rev;
					fill_bits = saved_q;
					result_o = fill_out_rev;
				end
			end
			default: result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/result_assembler.sv ====
`timescale 1ns/1ns
`default_nettype none

module result_assembler (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   half_valid_i,
	input  alu_data_pkg::half_t    half_i,
	input  logic                   is_high_i,
	input  logic                   last_i,
	input  logic                   cmp_i,
	input  logic                   cmp_valid_i,
	output logic                   rsp_valid_o,
	output alu_data_pkg::alu_rsp_t rsp_o
);
	import alu_data_pkg::*;

	half_t first_half_q;
	logic  suppress_q;
	logic  issue;
	word_t joined;

	// A compare answers on its first valid verdict, others on the last beat
	assign issue = half_valid_i && (last_i || cmp_valid_i) && !suppress_q;
	assign joined = is_high_i ? {half_i, first_half_q} : {first_half_q, half_i};

	always_ff @(posedge clk) begin
		if (half_valid_i && !last_i) begin
			first_half_q <= half_i;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rsp_valid_o <= 1'b0;
			suppress_q <= 1'b0;
		end else begin
			rsp_valid_o <= issue;
			// Early verdict already answered, drop the second beat
			if (half_valid_i && last_i) begin
				suppress_q <= 1'b0;
			end else if (issue) begin
				suppress_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			rsp_o.result <= cmp_valid_i ? {31'b0, cmp_i} : joined;
			rsp_o.cmp <= cmp_valid_i && cmp_i;
		end
	end

endmodule

`default_nettype wire

// ==== src/serial_alu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module serial_alu_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   req_valid_i,
	input  alu_data_pkg::alu_req_t req_i,
	output logic                   rsp_valid_o,
	output alu_data_pkg::alu_rsp_t rsp_o
);
	import alu_data_pkg::*;

	slice_beat_t beat;
	logic        beat_valid;
	logic        shift_big;
	half_t       slice_result;
	logic        cmp_result;
	logic        cmp_result_valid;

	operand_sequencer u_operand_sequencer (
		.clk          (clk),
		.rst_n        (rst_n),
		.req_valid_i  (req_valid_i),
		.req_i        (req_i),
		.shift_big_i  (shift_big),
		.beat_valid_o (beat_valid),
		.beat_o       (beat)
	);

	alu_sbm u_alu_sbm (
		.clk                    (clk),
		.rst_n                  (rst_n),
		.first_cycle            (beat.first),
		.op_i                   (beat.op),
		.cmp_req_i              (beat.cmp_req),
		.cmp_flip_i             (beat.cmp_flip),
		.a_i                    (beat.a),
		.b_i                    (beat.b),
		.shift_bigger_then_16_o (shift_big),
		.result_o               (slice_result),
		.cmp_result_o           (cmp_result),
		.cmp_result_valid_o     (cmp_result_valid)
	);

	result_assembler u_result_assembler (
		.clk          (clk),
		.rst_n        (rst_n),
		.half_valid_i (beat_valid),
		.half_i       (slice_result),
		.is_high_i    (beat.is_high),
		.last_i       (!beat.first),
		.cmp_i        (cmp_result),
		.cmp_valid_i  (cmp_result_valid),
		.rsp_valid_o  (rsp_valid_o),
		.rsp_o        (rsp_o)
	);

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Reset low over 16 rising edges, released on a falling edge
	initial begin
		rst_n = 1'b1;
		#1 rst_n = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== sim/serial_alu_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module serial_alu_properties (
	input logic clk,
	input logic rst_n,
	input logic req_valid_i,
	input logic rsp_valid_i
);

	reset_quiet: assert property (@(posedge clk) !rst_n |-> !rsp_valid_i)
		else $error("rsp_valid_o high while reset is asserted");

	// Two strobes can touch, a third one in a row cannot
	no_strobe_run: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid_i && $past(rsp_valid_i) |=> !rsp_valid_i)
		else $error("rsp_valid_o high for three cycles in a row");

	response_has_request: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid_i |-> $past(req_valid_i, 2) || $past(req_valid_i, 3))
		else $error("rsp_valid_o without a request 2 or 3 cycles before");

	// Early compares answer one cycle sooner
	request_answered: assert property (@(posedge clk) disable iff (!rst_n)
		$past(req_valid_i, 3) |-> rsp_valid_i || $past(rsp_valid_i))
		else $error("request got no response within 3 cycles");

endmodule

`default_nettype wire

// ==== sim/serial_alu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module serial_alu_tb;
	import alu_op_pkg::*;
	import alu_data_pkg::*;

	logic        clk;
	logic        rst_n;
	logic        req_valid;
	alu_req_t    req;
	logic        rsp_valid;
	alu_rsp_t    rsp;
	logic [31:0] seed = 32'h7424;
	int          errors = 0;
	int          checks = 0;

	tb_clock_gen u_tb_clock_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	serial_alu_top u_serial_alu_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_valid_i (req_valid),
		.req_i       (req),
		.rsp_valid_o (rsp_valid),
		.rsp_o       (rsp)
	);

	bind serial_alu_top serial_alu_properties u_serial_alu_properties (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_valid_i (req_valid_i),
		.rsp_valid_i (rsp_valid_o)
	);

	function automatic word_t next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic is_compare(cs_alu_op op);
		return op inside {ALU_OP_EQ, ALU_OP_LT, ALU_OP_LTU};
	endfunction

	// 32-bit results as the operation set defines them
	function automatic word_t model_result(cs_alu_op op, logic flip, word_t a, word_t b);
		word_t r;
		r = '0;
		case (op)
			ALU_OP_ADD:    r = a + b;
			ALU_OP_SUB:    r = a - b;
			ALU_OP_AND:    r = a & b;
			ALU_OP_OR:     r = a | b;
			ALU_OP_XOR:    r = a ^ b;
			ALU_OP_SLL:    r = a << b[4:0];
			ALU_OP_SRL:    r = a >> b[4:0];
			ALU_OP_SRA:    r = word_t'($signed(a) >>> b[4:0]);
			ALU_OP_EQ:     r = {31'b0, (a == b) ^ flip};
			ALU_OP_LT:     r = {31'b0, ($signed(a) < $signed(b)) ^ flip};
			ALU_OP_LTU:    r = {31'b0, (a < b) ^ flip};
			// Low half of b plus 4, high half untouched
			ALU_OP_PLUS_4: r = {b[31:16], b[15:0] + 16'd4};
			default:       r = '0;
		endcase
		return r;
	endfunction

	task automatic expect_equal(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic issue_request(input cs_alu_op op, input logic flip, input word_t a,
			input word_t b);
		req.op = op;
		req.flip = flip;
		req.a = a;
		req.b = b;
		req_valid = 1'b1;
		@(posedge clk);
		#2;
		req_valid = 1'b0;
	endtask

	// Latency counts rising edges from the strobe drive
	task automatic await_response(output int latency, output logic seen);
		latency = 1;
		seen = 1'b0;
		for (int i = 0; i < 10 && !seen; i++) begin
			@(posedge clk);
			#2;
			latency++;
			seen = rsp_valid;
		end
	endtask

	task automatic run_single(input cs_alu_op op, input logic flip, input word_t a,
			input word_t b);
		word_t expected;
		int    latency;
		int    want_latency;
		logic  seen;
		expected = model_result(op, flip, a, b);
		want_latency = (is_compare(op) && a[31:16] != b[31:16]) ? 2 : 3;
		issue_request(op, flip, a, b);
		await_response(latency, seen);
		if (!seen) begin
			errors++;
			$display("Timeout: no response to %s within 10 cycles", op.name());
		end else begin
			expect_equal($sformatf("%s/%0b rsp_o.result", op.name(), flip),
				rsp.result, expected);
			expect_equal($sformatf("%s/%0b rsp_o.cmp", op.name(), flip),
				{31'b0, rsp.cmp}, {31'b0, is_compare(op) & expected[0]});
			expect_equal($sformatf("%s latency", op.name()), latency, want_latency);
		end
	endtask

	task automatic add_sub_cases();
		word_t a, b;
		// Carry and borrow across bit 16
		run_single(ALU_OP_ADD, 1'b0, 32'h0000_FFFF, 32'h0000_0001);
		run_single(ALU_OP_ADD, 1'b0, 32'hFFFF_FFFF, 32'h0000_0001);
		run_single(ALU_OP_SUB, 1'b0, 32'h0001_0000, 32'h0000_0001);
		run_single(ALU_OP_SUB, 1'b0, 32'h0000_0000, 32'h0000_0001);
		repeat (8) begin
			a = next_rand();
			b = next_rand();
			run_single(ALU_OP_ADD, 1'b0, a, b);
			run_single(ALU_OP_SUB, 1'b0, a, b);
		end
	endtask

	task automatic logic_cases();
		word_t a, b;
		repeat (6) begin
			a = next_rand();
			b = next_rand();
			run_single(ALU_OP_AND, 1'b0, a, b);
			run_single(ALU_OP_OR, 1'b0, a, b);
			run_single(ALU_OP_XOR, 1'b0, a, b);
			// Low half kept clear of the wrap
			run_single(ALU_OP_PLUS_4, 1'b0, a, b & 32'hFFFF_7FFF);
		end
		run_single(ALU_OP_PLUS_4, 1'b0, a, 32'hFFFF_FFFB);
	endtask

	task automatic shift_cases();
		cs_alu_op   ops [3] = '{ALU_OP_SLL, ALU_OP_SRL, ALU_OP_SRA};
		logic [4:0] amounts [6] = '{5'd0, 5'd1, 5'd15, 5'd16, 5'd17, 5'd31};
		word_t      a, r;
		foreach (ops[k]) begin
			foreach (amounts[j]) begin
				r = next_rand();
				a = next_rand();
				run_single(ops[k], 1'b0, a & 32'h7FFF_FFFF, {r[31:5], amounts[j]});
				run_single(ops[k], 1'b0, a | 32'h8000_0000, {r[31:5], amounts[j]});
			end
			repeat (6) begin
				r = next_rand();
				a = next_rand();
				run_single(ops[k], 1'b0, a, r);
			end
		end
	endtask

	task automatic compare_cases();
		cs_alu_op ops [3] = '{ALU_OP_EQ, ALU_OP_LT, ALU_OP_LTU};
		word_t    a, b;
		foreach (ops[k]) begin
			for (int f = 0; f < 2; f++) begin
				a = next_rand();
				b = next_rand();
				if (b[31:16] == a[31:16]) b[16] = ~b[16];
				// High halves decide early
				run_single(ops[k], f[0], a, b);
				run_single(ops[k], f[0], 32'hFFFF_0000, 32'h0001_0000);
				// Equal high halves, low half decides
				run_single(ops[k], f[0], a, {a[31:16], b[15:0]});
				run_single(ops[k], f[0], 32'h1234_8000, 32'h1234_7FFF);
				run_single(ops[k], f[0], a, a);
			end
		end
	endtask

	task automatic back_to_back_cases();
		cs_alu_op    mix [16] = '{ALU_OP_ADD, ALU_OP_SUB, ALU_OP_AND, ALU_OP_OR,
			ALU_OP_XOR, ALU_OP_SLL, ALU_OP_SRL, ALU_OP_SRA, ALU_OP_EQ, ALU_OP_LT,
			ALU_OP_LTU, ALU_OP_PLUS_4, ALU_OP_EQ, ALU_OP_LT, ALU_OP_LTU, ALU_OP_ADD};
		logic [32:0] exp_q [$];
		fork
			begin : driver
				word_t    a, b, r, result;
				cs_alu_op op;
				for (int n = 0; n < 20; n++) begin
					r = next_rand();
					a = next_rand();
					b = next_rand();
					op = mix[r[11:8]];
					if (r[0]) b[31:16] = a[31:16];
					if (op == ALU_OP_PLUS_4) b[15] = 1'b0;
					result = model_result(op, r[4], a, b);
					exp_q.push_back({is_compare(op) & result[0], result});
					issue_request(op, r[4], a, b);
					@(posedge clk);
					#2;
				end
			end
			begin : collector
				logic        seen;
				logic [32:0] expected;
				seen = 1'b1;
				for (int n = 0; n < 20 && seen; n++) begin
					seen = 1'b0;
					for (int i = 0; i < 10 && !seen; i++) begin
						@(posedge clk);
						#2;
						seen = rsp_valid;
					end
					if (!seen) begin
						errors++;
						$display("Timeout: back-to-back response %0d never came", n);
					end else if (exp_q.size() == 0) begin
						errors++;
						$display("Response at %0t with no request pending", $time);
					end else begin
						expected = exp_q.pop_front();
						expect_equal("rsp_o.result", rsp.result, expected[31:0]);
						expect_equal("rsp_o.cmp", {31'b0, rsp.cmp}, {31'b0, expected[32]});
					end
				end
			end
		join
	endtask

	initial begin
		req_valid = 1'b0;
		req = '0;
		#5;
		for (int i = 0; i < 40 && !rst_n; i++) begin
			@(posedge clk);
			#2;
		end
		if (!rst_n) begin
			errors++;
			$display("Reset was never released");
		end else begin
			add_sub_cases();
			logic_cases();
			shift_cases();
			compare_cases();
			back_to_back_cases();
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== serial_alu.f ====
src/alu_op_pkg.sv
src/alu_data_pkg.sv
src/operand_sequencer.sv
src/alu_sbm.sv
src/result_assembler.sv
src/serial_alu_top.sv
sim/tb_clock_gen.sv
sim/serial_alu_properties.sv
sim/serial_alu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the serial ALU testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module serial_alu_tb \
	-f serial_alu.f -o Vserial_alu_tb > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/Vserial_alu_tb > "$LOG" 2>&1 \
	|| { echo "Simulation stopped with an error, see $LOG"; exit 1; }

grep -q "SOME TESTS FAILED" "$LOG" \
	&& { echo "Simulation reported failures, see $LOG"; exit 1; }
grep -q "ALL TESTS PASSED" "$LOG" \
	|| { echo "Simulation ended without a verdict, see $LOG"; exit 1; }
echo "Simulation passed"
